// File: all.f
+incdir+include
hdl/exPkg.sv
hdl/csrBus.sv
hdl/alu.sv
hdl/csrUnit.sv
hdl/stageEx.sv
verif/stageExTb.sv

// File: hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
    import exPkg::*;
(
    input  AluOp i_op,      // ALU function
    input  Data  i_dataA,   // Operand A
    input  Data  i_dataB,   // Operand B
    output Data  o_result   // Result, same cycle
);

    logic [SHAMT_BITS-1:0] shamt;     // Shift amount
    logic                  ltSigned;
    logic                  ltUnsigned;
    Data                   result;

    // ------------------------------
    // Compare and shift helpers
    // ------------------------------

    assign shamt      = i_dataB[SHAMT_BITS-1:0];           // Upper bits ignored
    assign ltSigned   = $signed(i_dataA) < $signed(i_dataB);
    assign ltUnsigned = i_dataA < i_dataB;

    // ------------------------------
    // Function select
    // ------------------------------

    always_comb begin
        case (i_op)
            AluOp_ADD:   result = i_dataA + i_dataB;        // Wraps mod 2^32
            AluOp_SUB:   result = i_dataA - i_dataB;
            AluOp_SLL:   result = i_dataA << shamt;
            AluOp_SLT:   result = Data'(ltSigned);          // 0 or 1
            AluOp_SLTU:  result = Data'(ltUnsigned);
            AluOp_XOR:   result = i_dataA ^ i_dataB;
            AluOp_SRL:   result = i_dataA >> shamt;         // Zero fill
            AluOp_SRA:   result = Data'($signed(i_dataA) >>> shamt);
            AluOp_OR:    result = i_dataA | i_dataB;
            AluOp_AND:   result = i_dataA & i_dataB;
            AluOp_PASSB: result = i_dataB;                  // LUI path
            default:     result = '0;                       // Unused codes
        endcase
    end

    assign o_result = result;

endmodule

`default_nettype wire

// File: hdl/csrBus.sv
`timescale 1ns/1ns
`default_nettype none

// One CSR access per cycle, no handshake
interface csrBus
    import exPkg::*;
();

    CsrOp   op;     // NOP means no access
    CsrAddr addr;   // CSR number
    Data    wdata;  // Source operand for RW/RS/RC
    Data    rdata;  // Old value, combinational from addr

    // Execute stage side
    modport stage (
        output op,
        output addr,
        output wdata,
        input  rdata);

    // CSR register file side
    modport unit (
        input  op,
        input  addr,
        input  wdata,
        output rdata);

endinterface

`default_nettype wire

// File: hdl/csrUnit.sv
`timescale 1ns/1ns
`default_nettype none

module csrUnit
    import exPkg::*;
(
    input  logic i_clock,     // Clock
    input  logic i_arstN,     // Async reset, active low
    input  logic i_instRet,   // Instruction retired this cycle
    csrBus.unit  csr          // Access from the stage
);

    // Architectural state
    Data    mscratch;
    Counter cycle;
    Counter instret;

    Data    readData;         // Old value at csr.addr
    Data    writeData;        // New value after RW/RS/RC
    logic   isWrite;

    // Per-register write strobes
    logic   wrScratch;
    logic   wrCycleL;
    logic   wrCycleH;
    logic   wrInstretL;
    logic   wrInstretH;

    // ------------------------------
    // Read side
    // ------------------------------

    always_comb begin
        case (csr.addr)
            CSR_MSCRATCH:               readData = mscratch;
            CSR_MCYCLE,    CSR_CYCLE:   readData = cycle[31:0];
            CSR_MCYCLEH,   CSR_CYCLEH:  readData = cycle[63:32];
            CSR_MINSTRET,  CSR_INSTRET: readData = instret[31:0];
            CSR_MINSTRETH, CSR_INSTRETH: readData = instret[63:32];
            default:                    readData = '0;   // Unknown CSR reads zero
        endcase
    end

    assign csr.rdata = readData;

    // ------------------------------
    // Write side
    // ------------------------------

    // Read-modify-write value, RS/RC with zero rewrite the old value
    always_comb begin
        case (csr.op)
            CsrOp_RW: writeData = csr.wdata;
            CsrOp_RS: writeData = readData | csr.wdata;
            CsrOp_RC: writeData = readData & ~csr.wdata;
            default:  writeData = readData;
        endcase
    end

    assign isWrite = csr.op != CsrOp_NOP;

    // Only machine-level copies are writable
    assign wrScratch  = isWrite && (csr.addr == CSR_MSCRATCH);
    assign wrCycleL   = isWrite && (csr.addr == CSR_MCYCLE);
    assign wrCycleH   = isWrite && (csr.addr == CSR_MCYCLEH);
    assign wrInstretL = isWrite && (csr.addr == CSR_MINSTRET);
    assign wrInstretH = isWrite && (csr.addr == CSR_MINSTRETH);

    // ------------------------------
    // Registers
    // ------------------------------

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN)
            mscratch <= '0;
        else if (wrScratch)
            mscratch <= writeData;
    end

    // Free-running, a write to either half takes priority over the increment
    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN)
            cycle <= '0;
        else if (wrCycleL)
            cycle <= {cycle[63:32], writeData};
        else if (wrCycleH)
            cycle <= {writeData, cycle[31:0]};
        else
            cycle <= cycle + Counter'(1);
    end

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN)
            instret <= '0;
        else if (wrInstretL)
            instret <= {instret[63:32], writeData};
        else if (wrInstretH)
            instret <= {writeData, instret[31:0]};
        else if (i_instRet)
            instret <= instret + Counter'(1);   // Count retired only
    end

    // ------------------------------
    // Assertions
    // ------------------------------

    // Stage must always present a defined op
    opKnown: assert property (@(posedge i_clock) disable iff (!i_arstN)
        !$isunknown(csr.op))
        else $error("csrUnit: unknown CSR op");

    // User alias is read only, so the counter keeps running
    cycleAliasReadOnly: assert property (@(posedge i_clock) disable iff (!i_arstN)
        (isWrite && csr.addr == CSR_CYCLE) |=> (cycle == $past(cycle) + Counter'(1)))
        else $error("csrUnit: write to cycle alias changed the counter");

endmodule

`default_nettype wire

// File: hdl/exPkg.sv
`default_nettype none

package exPkg;

    // ------------------------------
    // Widths
    // ------------------------------

    localparam int DATA_BITS    = 32;   // RV32 register width
    localparam int ADDR_BITS    = 32;   // Instruction address width
    localparam int CSR_BITS     = 12;   // Zicsr CSR number field
    localparam int COUNTER_BITS = 64;   // Full cycle/instret width
    localparam int SHAMT_BITS   = 5;    // Shift amount, low bits of B

    typedef logic [DATA_BITS-1:0]    Data;
    typedef logic [ADDR_BITS-1:0]    InstAddr;
    typedef logic [CSR_BITS-1:0]     CsrAddr;
    typedef logic [COUNTER_BITS-1:0] Counter;

    // ------------------------------
    // Operation codes
    // ------------------------------

    typedef enum logic [3:0] {
        AluOp_ADD   = 4'd0,
        AluOp_SUB   = 4'd1,
        AluOp_SLL   = 4'd2,
        AluOp_SLT   = 4'd3,     // Signed compare
        AluOp_SLTU  = 4'd4,     // Unsigned compare
        AluOp_XOR   = 4'd5,
        AluOp_SRL   = 4'd6,
        AluOp_SRA   = 4'd7,     // Arithmetic right shift
        AluOp_OR    = 4'd8,
        AluOp_AND   = 4'd9,
        AluOp_PASSB = 4'd10     // Operand B straight through (LUI)
    } AluOp;

    typedef enum logic [1:0] {
        CsrOp_NOP = 2'd0,
        CsrOp_RW  = 2'd1,       // Plain write
        CsrOp_RS  = 2'd2,       // Set bits
        CsrOp_RC  = 2'd3        // Clear bits
    } CsrOp;

    // Operand and result selectors
    typedef enum logic [1:0] {
        OperandASel_RS1  = 2'd0,
        OperandASel_IMM  = 2'd1,
        OperandASel_ZERO = 2'd2,
        OperandASel_PC   = 2'd3
    } OperandASel;

    typedef enum logic [1:0] {
        OperandBSel_RS2  = 2'd0,
        OperandBSel_IMM  = 2'd1,
        OperandBSel_FOUR = 2'd2  // Code 3 never used
    } OperandBSel;

    typedef enum logic {
        ResultSel_ALU = 1'b0,
        ResultSel_CSR = 1'b1
    } ResultSel;

    // ------------------------------
    // CSR numbers
    // ------------------------------

    localparam CsrAddr CSR_MSCRATCH  = 12'h340;
    localparam CsrAddr CSR_MCYCLE    = 12'hB00;   // Machine counters, writable
    localparam CsrAddr CSR_MINSTRET  = 12'hB02;
    localparam CsrAddr CSR_MCYCLEH   = 12'hB80;
    localparam CsrAddr CSR_MINSTRETH = 12'hB82;
    localparam CsrAddr CSR_CYCLE     = 12'hC00;   // User aliases, read only
    localparam CsrAddr CSR_INSTRET   = 12'hC02;
    localparam CsrAddr CSR_CYCLEH    = 12'hC80;
    localparam CsrAddr CSR_INSTRETH  = 12'hC82;

endpackage

`default_nettype wire

// File: hdl/stageEx.sv
`timescale 1ns/1ns
`default_nettype none

module stageEx
    import exPkg::*;
(
    input  logic       i_clock,        // Clock
    input  logic       i_arstN,        // Async reset, active low
    input  logic       i_isValid,      // Valid operation this cycle
    input  Data        i_instImm,      // Immediate field
    input  CsrAddr     i_instCsr,      // CSR number field
    input  Data        i_dataRs1,      // X[rs1]
    input  Data        i_dataRs2,      // X[rs2]
    input  InstAddr    i_pc,           // Instruction address
    input  OperandASel i_operandASel,
    input  OperandBSel i_operandBSel,
    input  ResultSel   i_resultSel,
    input  AluOp       i_aluControl,   // ALU function
    input  CsrOp       i_csrControl,   // CSR operation
    input  logic       i_instRet,      // Retire strobe for instret
    output Data        o_dataR,        // Result
    output Data        o_dataB         // Store data
);

    Data operandA;
    Data operandB;
    Data aluResult;
    Data result;

    // ------------------------------
    // Operand selection
    // ------------------------------

    always_comb begin
        case (i_operandASel)
            OperandASel_RS1:  operandA = i_dataRs1;
            OperandASel_IMM:  operandA = i_instImm;
            OperandASel_ZERO: operandA = '0;
            OperandASel_PC:   operandA = Data'(i_pc);   // AUIPC / JAL link
            default:          operandA = '0;
        endcase
    end

    always_comb begin
        case (i_operandBSel)
            OperandBSel_RS2:  operandB = i_dataRs2;
            OperandBSel_IMM:  operandB = i_instImm;
            OperandBSel_FOUR: operandB = Data'(4);      // PC + 4
            default:          operandB = '0;            // Illegal code
        endcase
    end

    // ------------------------------
    // Execution units
    // ------------------------------

    alu alu_i (
        .i_op     (i_aluControl),
        .i_dataA  (operandA),
        .i_dataB  (operandB),
        .o_result (aluResult));

    csrBus csrBus_i ();

    // Invalid slot turns into NOP so no CSR moves
    assign csrBus_i.op    = i_isValid ? i_csrControl : CsrOp_NOP;
    assign csrBus_i.addr  = i_instCsr;
    assign csrBus_i.wdata = operandA;               // rs1 or zimm via operand A

    csrUnit csrUnit_i (
        .i_clock   (i_clock),
        .i_arstN   (i_arstN),
        .i_instRet (i_instRet),
        .csr       (csrBus_i.unit));

    // ------------------------------
    // Result and outputs
    // ------------------------------

    always_comb begin
        case (i_resultSel)
            ResultSel_CSR: result = csrBus_i.rdata;   // Old CSR value
            default:       result = aluResult;
        endcase
    end

    assign o_dataR = result;
    assign o_dataB = i_dataRs2;    // Memory stage store data

    // Unused operand B code only allowed in bubbles
    operandBLegal: assert property (@(posedge i_clock) disable iff (!i_arstN)
        i_isValid |-> (i_operandBSel inside {OperandBSel_RS2, OperandBSel_IMM,
                                             OperandBSel_FOUR}))
        else $error("stageEx: illegal operand B select");

endmodule

`default_nettype wire

// File: include/exModel.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// Reference model, included inside the testbench module after the exPkg import

// Mirrored CSR state
Data    mdlScratch;
Counter mdlCycle;
Counter mdlInstret;

// Same function table as the ALU
function automatic Data modelAlu(AluOp op, Data a, Data b);
    logic [SHAMT_BITS-1:0] sh;
    sh = b[SHAMT_BITS-1:0];
    case (op)
        AluOp_ADD:   return a + b;
        AluOp_SUB:   return a - b;
        AluOp_SLL:   return a << sh;
        AluOp_SLT:   return Data'($signed(a) < $signed(b));
        AluOp_SLTU:  return Data'(a < b);
        AluOp_XOR:   return a ^ b;
        AluOp_SRL:   return a >> sh;
        AluOp_SRA:   return Data'($signed(a) >>> sh);
        AluOp_OR:    return a | b;
        AluOp_AND:   return a & b;
        AluOp_PASSB: return b;
        default:     return '0;
    endcase
endfunction

function automatic Data modelOperandA(OperandASel sel, Data rs1, Data imm, InstAddr pc);
    case (sel)
        OperandASel_RS1: return rs1;
        OperandASel_IMM: return imm;
        OperandASel_PC:  return Data'(pc);
        default:         return '0;   // Zero select
    endcase
endfunction

function automatic Data modelOperandB(OperandBSel sel, Data rs2, Data imm);
    case (sel)
        OperandBSel_RS2:  return rs2;
        OperandBSel_IMM:  return imm;
        OperandBSel_FOUR: return Data'(4);
        default:          return '0;
    endcase
endfunction

// Old value, unknown numbers read zero
function automatic Data modelCsrRead(CsrAddr addr);
    case (addr)
        CSR_MSCRATCH:                return mdlScratch;
        CSR_MCYCLE,    CSR_CYCLE:    return mdlCycle[31:0];
        CSR_MCYCLEH,   CSR_CYCLEH:   return mdlCycle[63:32];
        CSR_MINSTRET,  CSR_INSTRET:  return mdlInstret[31:0];
        CSR_MINSTRETH, CSR_INSTRETH: return mdlInstret[63:32];
        default:                     return '0;
    endcase
endfunction

task automatic modelReset();
    mdlScratch = '0;
    mdlCycle   = '0;
    mdlInstret = '0;
endtask

// One rising edge, called with the inputs of the cycle that ends
task automatic modelStep(logic valid, CsrOp op, CsrAddr addr, Data wdata, logic instRet);
    Data  oldVal;
    Data  newVal;
    logic wr;
    oldVal = modelCsrRead(addr);
    wr     = valid && (op != CsrOp_NOP);
    case (op)
        CsrOp_RW: newVal = wdata;
        CsrOp_RS: newVal = oldVal | wdata;
        CsrOp_RC: newVal = oldVal & ~wdata;
        default:  newVal = oldVal;
    endcase
    if (wr && addr == CSR_MSCRATCH)
        mdlScratch = newVal;
    // Counter half write replaces the increment
    if (wr && addr == CSR_MCYCLE)
        mdlCycle = {mdlCycle[63:32], newVal};
    else if (wr && addr == CSR_MCYCLEH)
        mdlCycle = {newVal, mdlCycle[31:0]};
    else
        mdlCycle = mdlCycle + Counter'(1);
    if (wr && addr == CSR_MINSTRET)
        mdlInstret = {mdlInstret[63:32], newVal};
    else if (wr && addr == CSR_MINSTRETH)
        mdlInstret = {newVal, mdlInstret[31:0]};
    else if (instRet)
        mdlInstret = mdlInstret + Counter'(1);
endtask

`endif

// File: verif/stageExTb.sv
`timescale 1ns/1ns
`default_nettype none

module stageExTb
    import exPkg::*;
();

    localparam int NUM_OPS = 2000;                  // Random operations after reset
    localparam int TIMEOUT = NUM_OPS * 4 + 200;     // ns

    // DUT inputs
    logic       i_clock;
    logic       i_arstN;
    logic       i_isValid;
    Data        i_instImm;
    CsrAddr     i_instCsr;
    Data        i_dataRs1;
    Data        i_dataRs2;
    InstAddr    i_pc;
    OperandASel i_operandASel;
    OperandBSel i_operandBSel;
    ResultSel   i_resultSel;
    AluOp       i_aluControl;
    CsrOp       i_csrControl;
    logic       i_instRet;

    // DUT outputs
    Data        o_dataR;
    Data        o_dataB;

    logic [15:0] lfsrState;     // Random source

    `include "exModel.svh"

    stageEx stageEx_i (.*);

    always #2 i_clock = ~i_clock;   // 4 ns period

    // ------------------------------
    // Random numbers
    // ------------------------------

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    // Mostly random words with an occasional compare/shift corner
    task automatic randomOperand(output Data v);
        logic [31:0] r;
        takeBits(3, r);
        if (r[2:0] == 3'd0) begin
            takeBits(2, r);
            case (r[1:0])
                2'd0:    v = 32'h0000_0000;
                2'd1:    v = 32'h8000_0000;   // Most negative
                2'd2:    v = 32'h7FFF_FFFF;   // Most positive
                default: v = 32'hFFFF_FFFF;
            endcase
        end else begin
            takeBits(32, v);
        end
    endtask

    // Defined CSR numbers plus one unknown
    function automatic CsrAddr pickCsr(logic [3:0] idx);
        case (idx)
            4'd0:    return CSR_MSCRATCH;
            4'd1:    return CSR_MCYCLE;
            4'd2:    return CSR_MINSTRET;
            4'd3:    return CSR_MCYCLEH;
            4'd4:    return CSR_MINSTRETH;
            4'd5:    return CSR_CYCLE;
            4'd6:    return CSR_INSTRET;
            4'd7:    return CSR_CYCLEH;
            4'd8:    return CSR_INSTRETH;
            default: return 12'h7C0;          // Unimplemented number that reads zero
        endcase
    endfunction

    task automatic driveRandom();
        logic [31:0] r;
        takeBits(3, r);
        i_isValid = r[2:0] != 3'd0;           // Mostly valid slots
        takeBits(1, r);
        i_instRet = r[0];
        randomOperand(i_dataRs1);
        randomOperand(i_dataRs2);
        randomOperand(i_instImm);
        takeBits(32, r);
        i_pc = {r[31:2], 2'b00};              // Word aligned
        takeBits(2, r);
        i_operandASel = OperandASel'(r[1:0]);
        takeBits(4, r);
        i_operandBSel = OperandBSel'(2'(r[3:0] % 4'd3));   // Legal codes only
        takeBits(4, r);
        i_aluControl = AluOp'(r[3:0] % 4'd11);
        takeBits(1, r);
        i_resultSel = ResultSel'(r[0]);
        takeBits(2, r);
        i_csrControl = CsrOp'(r[1:0]);
        takeBits(4, r);
        i_instCsr = pickCsr(r[3:0] % 4'd10);
    endtask

    // ------------------------------
    // Checks
    // ------------------------------

    task automatic checkValue(input string name, input Data got, input Data expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic checkOutputs();
        Data opA;
        Data opB;
        Data expected;
        opA = modelOperandA(i_operandASel, i_dataRs1, i_instImm, i_pc);
        opB = modelOperandB(i_operandBSel, i_dataRs2, i_instImm);
        if (i_resultSel == ResultSel_CSR)
            expected = modelCsrRead(i_instCsr);   // Value before the write
        else
            expected = modelAlu(i_aluControl, opA, opB);
        checkValue("o_dataR", o_dataR, expected);
        checkValue("o_dataB", o_dataB, i_dataRs2);  // Store data passthrough
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        lfsrState     = 16'd44;
        i_clock       = 1'b0;
        i_arstN       = 1'b0;
        i_isValid     = 1'b0;
        i_instImm     = '0;
        i_instCsr     = '0;
        i_dataRs1     = '0;
        i_dataRs2     = '0;
        i_pc          = '0;
        i_operandASel = OperandASel_RS1;
        i_operandBSel = OperandBSel_RS2;
        i_resultSel   = ResultSel_ALU;
        i_aluControl  = AluOp_ADD;
        i_csrControl  = CsrOp_NOP;
        i_instRet     = 1'b0;
        modelReset();

        repeat (2) @(posedge i_clock);
        #1 i_arstN = 1'b1;

        for (int n = 0; n < NUM_OPS; n++) begin
            @(posedge i_clock);
            // Mirror the edge with the inputs of the cycle that just ended
            modelStep(i_isValid, i_csrControl, i_instCsr,
                      modelOperandA(i_operandASel, i_dataRs1, i_instImm, i_pc), i_instRet);
            #1 driveRandom();
            #2 checkOutputs();                   // 3 ns after the edge
        end

        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Watchdog: the run did not finish within %0d ns", TIMEOUT);
        $display("TESTS FAILED");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire
